/* Makefile */
TOP := tb_event_builder
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps \
		-f project.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || { echo "simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* project.f */
+incdir+testbench
verilog/event_pkg.sv
verilog/event_ctrl_regs.sv
verilog/event_link_stats.sv
verilog/event_link_gate.sv
verilog/event_start_detect.sv
verilog/event_builder_top.sv
testbench/tb_event_builder.sv

/* testbench/tb_event_tasks.svh */
`ifndef TB_EVENT_TASKS_SVH
`define TB_EVENT_TASKS_SVH

//////////////////////////////////////////////////////////////////////
// bus and link drivers
//////////////////////////////////////////////////////////////////////

// entered and left just after a rising edge
task automatic bus_access(input logic we, input int idx, input logic [3:0] sel,
                          input logic [31:0] wdata, output logic [31:0] rdata);
    int waited = 0;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = REG_ADDR_W'(idx * 4);
    wb_sel   = sel;
    wb_dat_w = wdata;
    next_cycle();
    while (!wb_ack) begin
        if (waited == 16) begin
            report_timeout("register bus ack");
        end
        waited++;
        next_cycle();
    end
    // ack is due one cycle after the request
    check_value("bus_access ack latency", 32'h0, 32'(waited));
    rdata = wb_dat_r;
    // the write lands on the edge that samples ack
    next_cycle();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // idle cycle lets the registered ack drain
    next_cycle();
endtask

task automatic reg_write(input int idx, input logic [3:0] sel, input logic [31:0] data);
    logic [31:0] ignored;
    bus_access(1'b1, idx, sel, data, ignored);
endtask

task automatic expect_reg(input string name, input int idx, input logic [31:0] expected);
    logic [31:0] data;
    bus_access(1'b0, idx, 4'hf, 32'h0, data);
    check_value(name, expected, data);
endtask

// returns just after the edge that took the beat
task automatic offer_beat(input int link, input logic [31:0] data, input logic last,
                          output logic forwarded);
    int waited = 0;
    s_tdata[link]  = data;
    s_tlast[link]  = last;
    s_tvalid[link] = 1'b1;
    #1;
    while (!s_tready[link]) begin
        if (waited == 16) begin
            report_timeout("link input ready");
        end
        waited++;
        next_cycle();
        #1;
    end
    forwarded = m_tvalid[link];
    next_cycle();
    s_tvalid[link] = 1'b0;
    s_tlast[link]  = 1'b0;
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic test_reset_state();
    check_value("reset_state start_event", 32'h0, 32'(start_event));
    check_value("reset_state wb_ack", 32'h0, 32'(wb_ack));
    check_value("reset_state m_tvalid", 32'h0, 32'(m_tvalid));
    check_value("reset_state s_tready", 32'hf, 32'(s_tready));
    // upper eight indices mirror the lower eight
    for (int idx = 0; idx < 16; idx++) begin
        expect_reg($sformatf("reset_state reg %0d", idx), idx, 32'h0);
    end
endtask

task automatic test_discard_closed();
    logic [31:0] data;
    logic        fwd;
    m_tready = '0;
    for (int link = 0; link < NUM_LINKS; link++) begin
        for (int n = 0; n < link + 3; n++) begin
            take_random(LINK_DATA_W, data);
            offer_beat(link, data, (n == link + 2), fwd);
            check_value("discard_closed forwarded", 32'h0, 32'(fwd));
        end
    end
    for (int link = 0; link < NUM_LINKS; link++) begin
        expect_reg("discard_closed count", int'(REG_COUNT0) + link, 32'(link + 3));
        expect_reg("discard_closed shadow count", 12 + link, 32'(link + 3));
    end
endtask

task automatic test_forward_backpressure();
    logic [31:0] data;
    int          sent;
    int          cycles;
    event_open = 1'b1;
    // synchronizer latency plus margin
    repeat (5) next_cycle();
    for (int link = 0; link < NUM_LINKS; link++) begin
        sent   = 0;
        cycles = 0;
        take_random(LINK_DATA_W, data);
        while (sent < FWD_BEATS) begin
            if (cycles == 64) begin
                report_timeout("forwarded beats");
            end
            m_tready[link] = cycles[0];
            s_tdata[link]  = data;
            s_tlast[link]  = (sent == FWD_BEATS - 1);
            s_tvalid[link] = 1'b1;
            #1;
            check_value("forward s_tready", 32'(m_tready[link]), 32'(s_tready[link]));
            check_value("forward m_tvalid", 32'h1, 32'(m_tvalid[link]));
            if (m_tready[link]) begin
                check_value("forward data", data, m_tdata[link]);
                check_value("forward last", 32'(sent == FWD_BEATS - 1), 32'(m_tlast[link]));
                sent++;
                take_random(LINK_DATA_W, data);
            end
            cycles++;
            next_cycle();
        end
        s_tvalid[link] = 1'b0;
        s_tlast[link]  = 1'b0;
        m_tready[link] = 1'b0;
    end
    // the discard test left link + 3 beats on each counter
    for (int link = 0; link < NUM_LINKS; link++) begin
        expect_reg("forward count", int'(REG_COUNT0) + link, 32'(link + 3 + FWD_BEATS));
    end
endtask

task automatic test_start_priority();
    logic [3:0]  masks [6] = '{4'b0000, 4'b0001, 4'b0110, 4'b1011, 4'b0111, 4'b1111};
    logic [31:0] data;
    logic        fwd;
    int          lowest;
    m_tready = '1;
    foreach (masks[m]) begin
        reg_write(int'(REG_CTRL0), 4'b0010, 32'(masks[m]) << CTRL_MASK_LSB);
        expect_reg("start_priority mask", int'(REG_CTRL0), 32'(masks[m]) << CTRL_MASK_LSB);
        lowest = lowest_unmasked(masks[m]);
        for (int link = 0; link < NUM_LINKS; link++) begin
            take_random(LINK_DATA_W, data);
            offer_beat(link, data, 1'b1, fwd);
            check_value("start_priority forwarded", 32'h1, 32'(fwd));
            check_value("start_priority early", 32'h0, 32'(start_event));
            next_cycle();
            check_value("start_priority pulse", 32'(link == lowest), 32'(start_event));
            next_cycle();
            check_value("start_priority width", 32'h0, 32'(start_event));
        end
    end
    reg_write(int'(REG_CTRL0), 4'b0010, 32'h0);
endtask

task automatic test_event_reset();
    logic [31:0] data;
    logic        fwd;
    m_tready = '1;
    reg_write(int'(REG_CTRL0), 4'b0001, 32'h1);
    expect_reg("event_reset control", int'(REG_CTRL0), 32'h1);
    expect_reg("event_reset shadow control", 9, 32'h1);
    // beats offered now are dropped and not counted
    for (int link = 0; link < NUM_LINKS; link++) begin
        take_random(LINK_DATA_W, data);
        offer_beat(link, data, 1'b0, fwd);
        check_value("event_reset forwarded", 32'h0, 32'(fwd));
    end
    for (int link = 0; link < NUM_LINKS; link++) begin
        expect_reg("event_reset count", int'(REG_COUNT0) + link, 32'h0);
    end
    reg_write(int'(REG_CTRL0), 4'b0001, 32'h0);
    expect_reg("event_reset cleared control", int'(REG_CTRL0), 32'h0);
    for (int link = 0; link < NUM_LINKS; link++) begin
        take_random(LINK_DATA_W, data);
        offer_beat(link, data, 1'b0, fwd);
        check_value("event_reset restored forwarded", 32'h1, 32'(fwd));
    end
    for (int link = 0; link < NUM_LINKS; link++) begin
        expect_reg("event_reset restored count", int'(REG_COUNT0) + link, 32'h1);
    end
endtask

`endif

/* testbench/tb_event_builder.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_event_builder;

    import event_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int FWD_BEATS    = 6;

    logic                                   aclk;
    logic                                   rst_n;
    logic                                   wb_cyc;
    logic                                   wb_stb;
    logic                                   wb_we;
    logic [REG_ADDR_W-1:0]                  wb_adr;
    logic [REG_SEL_W-1:0]                   wb_sel;
    logic [REG_DATA_W-1:0]                  wb_dat_w;
    logic [REG_DATA_W-1:0]                  wb_dat_r;
    logic                                   wb_ack;
    logic                                   event_open;
    logic [NUM_LINKS-1:0][LINK_DATA_W-1:0]  s_tdata;
    link_vec_t                              s_tvalid;
    link_vec_t                              s_tlast;
    link_vec_t                              s_tready;
    logic [NUM_LINKS-1:0][LINK_DATA_W-1:0]  m_tdata;
    link_vec_t                              m_tvalid;
    link_vec_t                              m_tlast;
    link_vec_t                              m_tready;
    logic                                   start_event;

    logic [31:0] lfsr_state;

    event_builder_top #(
        .DATA_W (LINK_DATA_W)
    ) event_builder_top_i (
        .aclk            (aclk),
        .rst_n_i         (rst_n),
        .wb_cyc_i        (wb_cyc),
        .wb_stb_i        (wb_stb),
        .wb_we_i         (wb_we),
        .wb_adr_i        (wb_adr),
        .wb_sel_i        (wb_sel),
        .wb_dat_i        (wb_dat_w),
        .wb_dat_o        (wb_dat_r),
        .wb_ack_o        (wb_ack),
        .event_open_i    (event_open),
        .s_link_tdata_i  (s_tdata),
        .s_link_tvalid_i (s_tvalid),
        .s_link_tlast_i  (s_tlast),
        .s_link_tready_o (s_tready),
        .m_link_tdata_o  (m_tdata),
        .m_link_tvalid_o (m_tvalid),
        .m_link_tlast_o  (m_tlast),
        .m_link_tready_i (m_tready),
        .start_event_o   (start_event)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic take_random(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    function automatic int lowest_unmasked(input logic [3:0] mask);
        for (int i = 0; i < NUM_LINKS; i++) begin
            if (!mask[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // error reporting
    //////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Fail %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped on a timeout");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    `include "tb_event_tasks.svh"

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        lfsr_state = 32'd95448;
        rst_n      = 1'b0;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = '0;
        wb_sel     = '0;
        wb_dat_w   = '0;
        event_open = 1'b0;
        s_tdata    = '0;
        s_tvalid   = '0;
        s_tlast    = '0;
        m_tready   = '0;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        test_reset_state();
        test_discard_closed();
        test_forward_backpressure();
        test_start_priority();
        test_event_reset();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/event_builder_top.sv */
`timescale 1ns/10ps
`default_nettype none

module event_builder_top #(
    parameter int DATA_W = event_pkg::LINK_DATA_W
) (
    input  wire                                            aclk,
    input  wire                                            rst_n_i,
    // register bus
    input  wire                                            wb_cyc_i,
    input  wire                                            wb_stb_i,
    input  wire                                            wb_we_i,
    input  wire [event_pkg::REG_ADDR_W-1:0]                wb_adr_i,
    input  wire [event_pkg::REG_SEL_W-1:0]                 wb_sel_i,
    input  wire [event_pkg::REG_DATA_W-1:0]                wb_dat_i,
    output logic [event_pkg::REG_DATA_W-1:0]               wb_dat_o,
    output logic                                           wb_ack_o,
    // event acceptance level
    input  wire                                            event_open_i,
    // incoming links
    input  wire [event_pkg::NUM_LINKS-1:0][DATA_W-1:0]     s_link_tdata_i,
    input  event_pkg::link_vec_t                           s_link_tvalid_i,
    input  event_pkg::link_vec_t                           s_link_tlast_i,
    output event_pkg::link_vec_t                           s_link_tready_o,
    // forwarded links
    output logic [event_pkg::NUM_LINKS-1:0][DATA_W-1:0]    m_link_tdata_o,
    output event_pkg::link_vec_t                           m_link_tvalid_o,
    output event_pkg::link_vec_t                           m_link_tlast_o,
    input  event_pkg::link_vec_t                           m_link_tready_i,
    output logic                                           start_event_o
);

    import event_pkg::*;

    // counters are read whole over the register bus
    localparam int COUNT_W = REG_DATA_W;

    logic               event_reset;
    link_vec_t          link_mask;
    link_vec_t          in_beat;
    link_vec_t          last_beat;
    logic [COUNT_W-1:0] count0;
    logic [COUNT_W-1:0] count1;
    logic [COUNT_W-1:0] count2;
    logic [COUNT_W-1:0] count3;

    event_ctrl_regs event_ctrl_regs_i (
        .aclk          (aclk),
        .rst_n_i       (rst_n_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_sel_i      (wb_sel_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .count0_i      (count0),
        .count1_i      (count1),
        .count2_i      (count2),
        .count3_i      (count3),
        .event_reset_o (event_reset),
        .link_mask_o   (link_mask)
    );

    event_link_stats #(
        .COUNT_W (COUNT_W)
    ) event_link_stats_i (
        .aclk          (aclk),
        .rst_n_i       (rst_n_i),
        .event_reset_i (event_reset),
        .beat_i        (in_beat),
        .count0_o      (count0),
        .count1_o      (count1),
        .count2_o      (count2),
        .count3_o      (count3)
    );

    event_link_gate #(
        .DATA_W (DATA_W)
    ) event_link_gate_i (
        .aclk            (aclk),
        .rst_n_i         (rst_n_i),
        .event_open_i    (event_open_i),
        .event_reset_i   (event_reset),
        .s_link_tdata_i  (s_link_tdata_i),
        .s_link_tvalid_i (s_link_tvalid_i),
        .s_link_tlast_i  (s_link_tlast_i),
        .s_link_tready_o (s_link_tready_o),
        .m_link_tdata_o  (m_link_tdata_o),
        .m_link_tvalid_o (m_link_tvalid_o),
        .m_link_tlast_o  (m_link_tlast_o),
        .m_link_tready_i (m_link_tready_i),
        .in_beat_o       (in_beat),
        .last_beat_o     (last_beat)
    );

    event_start_detect event_start_detect_i (
        .aclk          (aclk),
        .rst_n_i       (rst_n_i),
        .event_reset_i (event_reset),
        .last_beat_i   (last_beat),
        .link_mask_i   (link_mask),
        .start_event_o (start_event_o)
    );

endmodule

`default_nettype wire

/* verilog/event_ctrl_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module event_ctrl_regs (
    input  wire                               aclk,
    input  wire                               rst_n_i,
    // register bus
    input  wire                               wb_cyc_i,
    input  wire                               wb_stb_i,
    input  wire                               wb_we_i,
    input  wire [event_pkg::REG_ADDR_W-1:0]   wb_adr_i,
    input  wire [event_pkg::REG_SEL_W-1:0]    wb_sel_i,
    input  wire [event_pkg::REG_DATA_W-1:0]   wb_dat_i,
    output logic [event_pkg::REG_DATA_W-1:0]  wb_dat_o,
    output logic                              wb_ack_o,
    // beat counters from the statistics block
    input  wire [31:0]                        count0_i,
    input  wire [31:0]                        count1_i,
    input  wire [31:0]                        count2_i,
    input  wire [31:0]                        count3_i,
    // control outputs
    output logic                              event_reset_o,
    output event_pkg::link_vec_t              link_mask_o
);

    import event_pkg::*;

    logic                  req;
    logic                  ack_q;
    logic                  wr_commit;
    reg_index_e            reg_idx;
    logic [REG_DATA_W-1:0] ctrl_word;
    logic [REG_DATA_W-1:0] rd_data;
    logic [REG_DATA_W-1:0] dat_q;
    logic                  event_reset_q;
    link_vec_t             link_mask_q;

    //////////////////////////////////////////////////////////////////////
    // bus decode
    //////////////////////////////////////////////////////////////////////

    assign req = wb_cyc_i && wb_stb_i;

    // bit 5 is ignored so the upper half of the map mirrors the lower
    assign reg_idx = reg_index_e'(wb_adr_i[4:2]);

    // ack goes out one cycle after the request is presented
    assign wb_ack_o = ack_q && wb_cyc_i;

    // writes land on the edge where the master sees ack
    assign wr_commit = req && wb_ack_o && wb_we_i;

    //////////////////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_RESET_BIT] = event_reset_q;
        ctrl_word[CTRL_MASK_LSB +: NUM_LINKS] = link_mask_q;
    end

    always_comb begin
        case (reg_idx)
            REG_CTRL0, REG_CTRL1,
            REG_CTRL2, REG_CTRL3: rd_data = ctrl_word;
            REG_COUNT0:           rd_data = count0_i;
            REG_COUNT1:           rd_data = count1_i;
            REG_COUNT2:           rd_data = count2_i;
            REG_COUNT3:           rd_data = count3_i;
            default:              rd_data = ctrl_word;
        endcase
    end

    // capture in the request cycle, held while ack is up
    always_ff @(posedge aclk) begin
        if (req && !ack_q) begin
            dat_q <= rd_data;
        end
    end

    assign wb_dat_o = dat_q;

    //////////////////////////////////////////////////////////////////////
    // ack and control state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q         <= 1'b0;
            event_reset_q <= 1'b0;
            link_mask_q   <= '0;
        end else begin
            ack_q <= req;
            if (wr_commit) begin
                // byte lane 0 holds the reset bit, lane 1 the mask
                if (wb_sel_i[0]) begin
                    event_reset_q <= wb_dat_i[CTRL_RESET_BIT];
                end
                if (wb_sel_i[1]) begin
                    link_mask_q <= wb_dat_i[CTRL_MASK_LSB +: NUM_LINKS];
                end
            end
        end
    end

    assign event_reset_o = event_reset_q;
    assign link_mask_o   = link_mask_q;

endmodule

`default_nettype wire

/* verilog/event_link_gate.sv */
`timescale 1ns/10ps
`default_nettype none

module event_link_gate #(
    parameter int DATA_W = 32
) (
    input  wire                                            aclk,
    input  wire                                            rst_n_i,
    // event_open_i comes from another clock domain
    input  wire                                            event_open_i,
    input  wire                                            event_reset_i,
    // links from the readout boards
    input  wire [event_pkg::NUM_LINKS-1:0][DATA_W-1:0]     s_link_tdata_i,
    input  event_pkg::link_vec_t                           s_link_tvalid_i,
    input  event_pkg::link_vec_t                           s_link_tlast_i,
    output event_pkg::link_vec_t                           s_link_tready_o,
    // forwarded links
    output logic [event_pkg::NUM_LINKS-1:0][DATA_W-1:0]    m_link_tdata_o,
    output event_pkg::link_vec_t                           m_link_tvalid_o,
    output event_pkg::link_vec_t                           m_link_tlast_o,
    input  event_pkg::link_vec_t                           m_link_tready_i,
    // handshake reports
    output event_pkg::link_vec_t                           in_beat_o,
    output event_pkg::link_vec_t                           last_beat_o
);

    import event_pkg::*;

    logic open_meta_q;
    logic open_q;
    logic accepting;

    //////////////////////////////////////////////////////////////////////
    // event_open synchronizer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            open_meta_q <= 1'b0;
            open_q      <= 1'b0;
        end else begin
            open_meta_q <= event_open_i;
            open_q      <= open_meta_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // discard or forward
    //////////////////////////////////////////////////////////////////////

    assign accepting = open_q && !event_reset_i;

    // closed links swallow every beat by holding ready high
    assign m_link_tvalid_o = s_link_tvalid_i & {NUM_LINKS{accepting}};
    assign s_link_tready_o = m_link_tready_i | {NUM_LINKS{!accepting}};

    // payload is untouched either way
    assign m_link_tdata_o = s_link_tdata_i;
    assign m_link_tlast_o = s_link_tlast_i;

    // every taken beat counts, only forwarded lasts start events
    assign in_beat_o   = s_link_tvalid_i & s_link_tready_o;
    assign last_beat_o = m_link_tvalid_o & m_link_tready_i & s_link_tlast_i;

endmodule

`default_nettype wire

/* verilog/event_link_stats.sv */
`timescale 1ns/10ps
`default_nettype none

module event_link_stats #(
    parameter int COUNT_W = 32
) (
    input  wire                  aclk,
    input  wire                  rst_n_i,
    input  wire                  event_reset_i,
    // one strobe per input handshake, forwarded or discarded
    input  event_pkg::link_vec_t beat_i,
    output logic [COUNT_W-1:0]   count0_o,
    output logic [COUNT_W-1:0]   count1_o,
    output logic [COUNT_W-1:0]   count2_o,
    output logic [COUNT_W-1:0]   count3_o
);

    import event_pkg::*;

    logic [COUNT_W-1:0] count_q [NUM_LINKS];

    //////////////////////////////////////////////////////////////////////
    // beat counters
    //////////////////////////////////////////////////////////////////////

    // counters wrap, and stay cleared while the soft reset is set
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_LINKS; i++) begin
                count_q[i] <= '0;
            end
        end else if (event_reset_i) begin
            for (int i = 0; i < NUM_LINKS; i++) begin
                count_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_LINKS; i++) begin
                if (beat_i[i]) begin
                    count_q[i] <= count_q[i] + COUNT_W'(1);
                end
            end
        end
    end

    assign count0_o = count_q[0];
    assign count1_o = count_q[1];
    assign count2_o = count_q[2];
    assign count3_o = count_q[3];

endmodule

`default_nettype wire

/* verilog/event_pkg.sv */
`default_nettype none

package event_pkg;

    //////////////////////////////////////////////////////////////////////
    // link side
    //////////////////////////////////////////////////////////////////////

    // readout board links feeding the builder
    parameter int NUM_LINKS   = 4;
    parameter int LINK_DATA_W = 32;

    // one bit per link (valid, ready, last, mask, count enables)
    typedef logic [NUM_LINKS-1:0] link_vec_t;

    //////////////////////////////////////////////////////////////////////
    // register bus
    //////////////////////////////////////////////////////////////////////

    parameter int REG_DATA_W = 32;
    // byte address, word index is bits 5:2 with bit 5 shadowed
    parameter int REG_ADDR_W = 6;
    parameter int REG_SEL_W  = REG_DATA_W / 8;

    // decoded word index, top address bit dropped
    typedef enum logic [2:0] {
        REG_CTRL0  = 3'd0,
        REG_CTRL1  = 3'd1,
        REG_CTRL2  = 3'd2,
        REG_CTRL3  = 3'd3,
        REG_COUNT0 = 3'd4,
        REG_COUNT1 = 3'd5,
        REG_COUNT2 = 3'd6,
        REG_COUNT3 = 3'd7
    } reg_index_e;

    // control word layout
    parameter int CTRL_RESET_BIT = 0;
    parameter int CTRL_MASK_LSB  = 8;

endpackage

`default_nettype wire

/* verilog/event_start_detect.sv */
`timescale 1ns/10ps
`default_nettype none

module event_start_detect (
    input  wire                  aclk,
    input  wire                  rst_n_i,
    input  wire                  event_reset_i,
    // forwarded last beats, one bit per link
    input  event_pkg::link_vec_t last_beat_i,
    // a set bit removes the link from start selection
    input  event_pkg::link_vec_t link_mask_i,
    output logic                 start_event_o
);

    import event_pkg::*;

    link_vec_t last_q;
    logic      found;
    logic      pick;
    logic      start_q;

    //////////////////////////////////////////////////////////////////////
    // priority select
    //////////////////////////////////////////////////////////////////////

    // the lowest unmasked link decides, all masked gives nothing
    always_comb begin
        found = 1'b0;
        pick  = 1'b0;
        for (int i = 0; i < NUM_LINKS; i++) begin
            if (!found && !link_mask_i[i]) begin
                pick  = last_q[i];
                found = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pipeline
    //////////////////////////////////////////////////////////////////////

    // stage one holds the detected lasts, stage two the pulse
    always_ff @(posedge aclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            last_q  <= '0;
            start_q <= 1'b0;
        end else if (event_reset_i) begin
            last_q  <= '0;
            start_q <= 1'b0;
        end else begin
            last_q  <= last_beat_i;
            start_q <= pick;
        end
    end

    assign start_event_o = start_q;

endmodule

`default_nettype wire
